/* sources.f */
design/mcu_cfg_pkg.sv
design/pwr_pkg.sv
design/pwr_cmd_regs.sv
design/pwr_sequencer.sv
design/domain_gate_bank.sv
design/irq_vector.sv
design/mcu_ao_top.sv
sim/tb_mcu_ao.sv

/* Makefile */
# Verilator simulation of the always-on power and interrupt block

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mcu_ao -Mdir obj_dir
	./obj_dir/Vtb_mcu_ao > sim.log
	@cat sim.log
	@if grep -F -q '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* sim/ao_patterns.txt */
// kind_addr_wdata_sleep_fastirq_expected, kind 0 write then status, 1 write and move on
// kind 2 fast irq pulse then wait for the wake sequence, 3 write then read the same address
0_0_00000006_0_0000_0000000D
0_0_00000005_0_0000_0000000F
0_0_0000000B_0_0000_0000004B
0_0_00000007_0_0000_0000024B
0_1_00000000_0_0000_0000004B
0_0_00000002_0_0000_0000024B
0_1_00000000_0_0000_0000004B
0_0_00000002_1_0000_0000004A
3_2_00040000_1_0000_00040000
2_0_00000000_1_0004_0000004B
3_3_00000000_1_0000_00040000
3_3_00040000_1_0000_00000000
1_0_0000000E_1_0000_00000000
0_0_00000009_1_0000_00000243
0_1_00000000_1_0000_00000043
0_0_00000009_1_0000_00000007
0_0_00000011_1_0000_00000207
0_1_00000000_1_0000_00000007
0_0_00000005_1_0000_00000007

/* sim/tb_mcu_ao.sv */
// testbench for the always-on power and interrupt block
// replays register patterns, models the power switches and checks the gate order

module tb_mcu_ao;

  localparam int NUM_DOM  = 4;
  localparam int FAST_W   = 15;
  localparam int MAX_PAT  = 64;
  localparam int HALF_PER = 20;

  // pattern kinds
  localparam logic [3:0] KIND_NOWAIT = 4'd1;
  localparam logic [3:0] KIND_WAKE   = 4'd2;
  localparam logic [3:0] KIND_READ   = 4'd3;

  logic                               clk_i;
  logic                               reset_i;
  logic                               reg_we_i;
  logic [mcu_cfg_pkg::REG_ADDR_W-1:0] reg_addr_i;
  logic [mcu_cfg_pkg::REG_DATA_W-1:0] reg_wdata_i;
  logic [mcu_cfg_pkg::REG_DATA_W-1:0] reg_rdata_o;
  logic                               core_sleep_i;
  logic [FAST_W-1:0]                  fast_irq_i;
  logic                               timer_irq_i;
  logic                               ext_irq_i;
  logic [31:0]                        irq_o;
  logic [NUM_DOM-1:0]                 switch_ack_ni = '0;
  logic [NUM_DOM-1:0]                 switch_no;
  logic [NUM_DOM-1:0]                 rst_no;
  logic [NUM_DOM-1:0]                 iso_no;
  logic [NUM_DOM-1:0]                 clkgate_no;
  logic [NUM_DOM-1:0]                 retentive_no;
  logic                               busy_o;

  logic [91:0]        pat_mem [MAX_PAT];
  int                 pat_count   = 0;
  int                 check_count = 0;
  int                 err_count   = 0;
  logic [31:0]        lcg_state   = 32'h30d8_60f3;
  logic [NUM_DOM-1:0] ack_target  = '0;
  int                 ack_wait [NUM_DOM];
  logic [NUM_DOM-1:0] prev_sw;
  logic [NUM_DOM-1:0] prev_rst;
  logic [NUM_DOM-1:0] prev_iso;
  logic [NUM_DOM-1:0] prev_clk;

  mcu_ao_top #(
    .NUM_DOMAINS(NUM_DOM),
    .FAST_IRQ_W (FAST_W)
  ) dut_i (
    .clk_i, .reset_i, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .core_sleep_i, .fast_irq_i, .timer_irq_i, .ext_irq_i, .irq_o,
    .switch_ack_ni, .switch_no, .rst_no, .iso_no, .clkgate_no, .retentive_no, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(HALF_PER) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("error at time %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // switch cells answer with the switch state after 1 to 8 cycles
  always @(negedge clk_i) begin
    for (int d = 0; d < NUM_DOM; d++) begin
      if (reset_i) begin
        ack_target[d] = 1'b0;
        ack_wait[d]   = 0;
      end else if (switch_no[d] != ack_target[d]) begin
        ack_target[d] = switch_no[d];
        ack_wait[d]   = 1 + (int'(lcg_next() >> 16) % 8);
      end else if (ack_wait[d] > 0) begin
        ack_wait[d] = ack_wait[d] - 1;
        if (ack_wait[d] == 0) begin
          switch_ack_ni[d] <= ack_target[d];
        end
      end
    end
  end

  // every gate edge must find the other gates in the state the step order allows
  always @(negedge clk_i) begin
    if (!reset_i) begin
      for (int d = 0; d < NUM_DOM; d++) begin
        if (prev_clk[d] && !clkgate_no[d]) begin
          check_value(32'({switch_no[d], rst_no[d], iso_no[d], retentive_no[d]}), 32'h7,
                      $sformatf("domain %0d clock gated while not running", d));
        end
        if (prev_iso[d] && !iso_no[d]) begin
          check_value(32'(clkgate_no[d]), 32'h0,
                      $sformatf("domain %0d isolated before its clock stopped", d));
        end
        if (prev_rst[d] && !rst_no[d]) begin
          check_value(32'({clkgate_no[d], iso_no[d]}), 32'h0,
                      $sformatf("domain %0d reset before clock gate and isolation", d));
        end
        if (!prev_sw[d] && switch_no[d]) begin
          check_value(32'({clkgate_no[d], iso_no[d], rst_no[d]}), 32'h0,
                      $sformatf("domain %0d switched off too early", d));
        end
        // power-up releases reset only after the acknowledge
        if (!prev_rst[d] && rst_no[d]) begin
          check_value(32'({switch_no[d], switch_ack_ni[d], iso_no[d], clkgate_no[d]}), 32'h0,
                      $sformatf("domain %0d reset released before the switch acknowledge", d));
        end
        if (!prev_iso[d] && iso_no[d]) begin
          check_value(32'({switch_no[d], rst_no[d], clkgate_no[d], retentive_no[d]}), 32'h5,
                      $sformatf("domain %0d isolation released out of order", d));
        end
        if (!prev_clk[d] && clkgate_no[d]) begin
          check_value(32'({switch_no[d], rst_no[d], iso_no[d], retentive_no[d]}), 32'h7,
                      $sformatf("domain %0d clock enabled out of order", d));
        end
      end
    end
    prev_sw  = switch_no;
    prev_rst = rst_no;
    prev_iso = iso_no;
    prev_clk = clkgate_no;
  end

  task automatic wait_idle();
    while (busy_o) begin
      @(negedge clk_i);
    end
  endtask

  // gate outputs implied by the on and retained bits of a status word
  task automatic check_gates(input logic [31:0] status);
    logic [4:0]         code;
    logic [NUM_DOM-1:0] exp_sw;
    logic [NUM_DOM-1:0] exp_rst;
    logic [NUM_DOM-1:0] exp_iso;
    logic [NUM_DOM-1:0] exp_clk;
    logic [NUM_DOM-1:0] exp_ret;
    for (int d = 0; d < NUM_DOM; d++) begin
      if (status[d]) begin
        code = 5'b01111;
      end else if (status[4 + d]) begin
        code = 5'b01000;
      end else begin
        code = 5'b10001;
      end
      exp_sw[d]  = code[4];
      exp_rst[d] = code[3];
      exp_iso[d] = code[2];
      exp_clk[d] = code[1];
      exp_ret[d] = code[0];
    end
    check_value(32'(switch_no), 32'(exp_sw), "switch outputs");
    check_value(32'(rst_no), 32'(exp_rst), "reset outputs");
    check_value(32'(iso_no), 32'(exp_iso), "isolation outputs");
    check_value(32'(clkgate_no), 32'(exp_clk), "clock gate outputs");
    check_value(32'(retentive_no), 32'(exp_ret), "retention outputs");
  endtask

  task automatic check_status(input logic [31:0] expected);
    reg_addr_i = mcu_cfg_pkg::ADDR_STATUS;
    @(negedge clk_i);
    check_value(reg_rdata_o, expected, "status readback");
    check_gates(expected);
  endtask

  // software irq at bit 3, timer at bit 7, external at bit 11
  task automatic drive_level_irqs();
    timer_irq_i = 1'b1;
    ext_irq_i   = 1'b1;
    reg_we_i    = 1'b1;
    reg_addr_i  = mcu_cfg_pkg::ADDR_SW_IRQ;
    reg_wdata_i = 32'h1;
    @(negedge clk_i);
    reg_we_i = 1'b0;
    check_value(irq_o, 32'h0000_0888, "software, timer and external interrupt bits");
    timer_irq_i = 1'b0;
    ext_irq_i   = 1'b0;
    reg_we_i    = 1'b1;
    reg_wdata_i = 32'h0;
    @(negedge clk_i);
    reg_we_i = 1'b0;
    check_value(irq_o, 32'h0, "interrupt vector with all levels low");
  endtask

  task automatic run_pattern(input logic [91:0] pat);
    logic [3:0]  kind;
    logic [31:0] expected;
    int          spin;
    kind         = pat[91:88];
    expected     = pat[31:0];
    core_sleep_i = pat[48];
    if (kind == KIND_WAKE) begin
      fast_irq_i = pat[32 +: FAST_W];
    end else begin
      reg_we_i    = 1'b1;
      reg_addr_i  = pat[87:84];
      reg_wdata_i = pat[83:52];
    end
    @(negedge clk_i);
    reg_we_i   = 1'b0;
    fast_irq_i = '0;
    if (kind == KIND_WAKE) begin
      spin = 0;
      while (!busy_o && spin < 40) begin
        @(negedge clk_i);
        spin++;
      end
      check_value(32'(busy_o), 32'h1, "wake request starts the sequencer");
      // fast irqs occupy vector bits 16 to 30
      check_value(irq_o, {1'b0, pat[32 +: FAST_W], 16'h0}, "fast interrupt pending in the vector");
    end
    // a no-wait line leaves the sequencer busy for the next write
    if (kind != KIND_NOWAIT) begin
      wait_idle();
      if (kind == KIND_READ) begin
        @(negedge clk_i);
        check_value(reg_rdata_o, expected,
                    $sformatf("readback of address %0d", pat[87:84]));
      end else begin
        check_status(expected);
      end
    end
  endtask

  initial begin
    reset_i      = 1'b1;
    reg_we_i     = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    core_sleep_i = 1'b0;
    fast_irq_i   = '0;
    timer_irq_i  = 1'b0;
    ext_irq_i    = 1'b0;
    for (int i = 0; i < MAX_PAT; i++) begin
      pat_mem[i] = '1;
    end
    $readmemh("sim/ao_patterns.txt", pat_mem);
    while (pat_count < MAX_PAT && pat_mem[pat_count][91:88] != 4'hf) begin
      pat_count++;
    end
    if (pat_count == 0) begin
      $display("pattern file sim/ao_patterns.txt could not be read or holds no lines");
      err_count++;
    end else begin
      repeat (16) @(negedge clk_i);
      reset_i = 1'b0;
      @(negedge clk_i);
      check_value(irq_o, 32'h0, "interrupt vector after reset");
      check_status(32'h0000_000f);
      drive_level_irqs();
      for (int i = 0; i < pat_count; i++) begin
        run_pattern(pat_mem[i]);
      end
    end
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog scaled by the number of patterns
  initial begin
    wait (pat_count != 0);
    repeat (pat_count * 200) @(posedge clk_i);
    $display("run timed out after %0d clock cycles", pat_count * 200);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* design/mcu_ao_top.sv */
// always-on power and interrupt block of the mini MCU
// register port, power sequencer, domain gates and interrupt vector

module mcu_ao_top #(
  parameter int unsigned NUM_DOMAINS = 4,
  parameter int unsigned FAST_IRQ_W  = 15
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               reg_we_i,
  input  logic [mcu_cfg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [mcu_cfg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [mcu_cfg_pkg::REG_DATA_W-1:0] reg_rdata_o,
  input  logic                               core_sleep_i,
  input  logic [FAST_IRQ_W-1:0]              fast_irq_i,
  input  logic                               timer_irq_i,
  input  logic                               ext_irq_i,
  output logic [31:0]                        irq_o,
  input  logic [NUM_DOMAINS-1:0]             switch_ack_ni,
  output logic [NUM_DOMAINS-1:0]             switch_no,
  output logic [NUM_DOMAINS-1:0]             rst_no,
  output logic [NUM_DOMAINS-1:0]             iso_no,
  output logic [NUM_DOMAINS-1:0]             clkgate_no,
  output logic [NUM_DOMAINS-1:0]             retentive_no,
  output logic                               busy_o
);

  localparam int unsigned DOM_W = (NUM_DOMAINS > 1) ? $clog2(NUM_DOMAINS) : 1;

  logic                   cmd_valid;
  pwr_pkg::pwr_cmd_u      cmd_word;
  logic [31:0]            irq_en;
  logic [FAST_IRQ_W-1:0]  pend_clr;
  logic                   sw_irq;
  logic                   dropped;
  logic [NUM_DOMAINS-1:0] dom_on;
  logic [NUM_DOMAINS-1:0] dom_ret;
  pwr_pkg::pwr_step_e     step;
  logic [DOM_W-1:0]       step_dom;
  logic                   ack_on;
  logic                   ack_off;
  logic                   wake;

  pwr_cmd_regs #(
    .NUM_DOMAINS(NUM_DOMAINS),
    .FAST_IRQ_W (FAST_IRQ_W)
  ) pwr_cmd_regs_i (
    .clk_i, .reset_i, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .busy_i(busy_o), .dropped_i(dropped), .dom_on_i(dom_on), .dom_ret_i(dom_ret),
    .pending_i(irq_o), .cmd_valid_o(cmd_valid), .cmd_word_o(cmd_word),
    .irq_en_o(irq_en), .pend_clr_o(pend_clr), .sw_irq_o(sw_irq)
  );

  pwr_sequencer #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) pwr_sequencer_i (
    .clk_i, .reset_i, .cmd_valid_i(cmd_valid), .cmd_word_i(cmd_word), .core_sleep_i,
    .wake_i(wake), .ack_on_i(ack_on), .ack_off_i(ack_off), .step_o(step),
    .step_dom_o(step_dom), .busy_o, .dropped_o(dropped), .dom_on_o(dom_on),
    .dom_ret_o(dom_ret)
  );

  domain_gate_bank #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) domain_gate_bank_i (
    .clk_i, .reset_i, .step_i(step), .step_dom_i(step_dom), .switch_ack_ni,
    .switch_no, .rst_no, .iso_no, .clkgate_no, .retentive_no,
    .ack_on_o(ack_on), .ack_off_o(ack_off)
  );

  irq_vector #(
    .FAST_IRQ_W(FAST_IRQ_W)
  ) irq_vector_i (
    .clk_i, .reset_i, .fast_irq_i, .pend_clr_i(pend_clr), .timer_irq_i, .ext_irq_i,
    .sw_irq_i(sw_irq), .irq_en_i(irq_en), .irq_o, .wake_o(wake)
  );

endmodule

/* design/irq_vector.sv */
// machine interrupt vector
// latches fast interrupts, assembles the vector and flags a wake request

module irq_vector #(
  parameter int unsigned FAST_IRQ_W = 15
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [FAST_IRQ_W-1:0] fast_irq_i,
  input  logic [FAST_IRQ_W-1:0] pend_clr_i,
  input  logic                  timer_irq_i,
  input  logic                  ext_irq_i,
  input  logic                  sw_irq_i,
  input  logic [31:0]           irq_en_i,
  output logic [31:0]           irq_o,
  output logic                  wake_o
);

  logic [FAST_IRQ_W-1:0] pend_q;

  // a live input beats the clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~pend_clr_i) | fast_irq_i;
    end
  end

  // unused vector positions stay zero
  always_comb begin
    irq_o                                          = '0;
    irq_o[mcu_cfg_pkg::IRQ_SW_BIT]                 = sw_irq_i;
    irq_o[mcu_cfg_pkg::IRQ_TIMER_BIT]              = timer_irq_i;
    irq_o[mcu_cfg_pkg::IRQ_EXT_BIT]                = ext_irq_i;
    irq_o[mcu_cfg_pkg::IRQ_FAST_LSB +: FAST_IRQ_W] = pend_q;
  end

  assign wake_o = |(irq_o & irq_en_i);

endmodule

/* design/domain_gate_bank.sv */
// per-domain power gate outputs
// applies sequencer steps and synchronizes the switch acknowledges

module domain_gate_bank #(
  parameter int unsigned NUM_DOMAINS = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  pwr_pkg::pwr_step_e     step_i,
  input  logic [((NUM_DOMAINS > 1) ? $clog2(NUM_DOMAINS) : 1)-1:0] step_dom_i,
  input  logic [NUM_DOMAINS-1:0] switch_ack_ni,
  output logic [NUM_DOMAINS-1:0] switch_no,
  output logic [NUM_DOMAINS-1:0] rst_no,
  output logic [NUM_DOMAINS-1:0] iso_no,
  output logic [NUM_DOMAINS-1:0] clkgate_no,
  output logic [NUM_DOMAINS-1:0] retentive_no,
  output logic                   ack_on_o,
  output logic                   ack_off_o
);

  // ack_n low means the domain is powered
  logic [NUM_DOMAINS-1:0] ack_meta_q;
  logic [NUM_DOMAINS-1:0] ack_sync_q;

  // all domains come out of reset powered and running
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_no    <= '0;
      rst_no       <= '1;
      iso_no       <= '1;
      clkgate_no   <= '1;
      retentive_no <= '1;
    end else begin
      case (step_i)
        pwr_pkg::CLK_OFF: clkgate_no[step_dom_i]   <= 1'b0;
        pwr_pkg::CLK_ON:  clkgate_no[step_dom_i]   <= 1'b1;
        pwr_pkg::ISO_ON:  iso_no[step_dom_i]       <= 1'b0;
        pwr_pkg::ISO_OFF: iso_no[step_dom_i]       <= 1'b1;
        pwr_pkg::RST_ON:  rst_no[step_dom_i]       <= 1'b0;
        pwr_pkg::RST_OFF: rst_no[step_dom_i]       <= 1'b1;
        pwr_pkg::SW_OFF:  switch_no[step_dom_i]    <= 1'b1;
        pwr_pkg::SW_ON:   switch_no[step_dom_i]    <= 1'b0;
        pwr_pkg::RET_ON:  retentive_no[step_dom_i] <= 1'b0;
        pwr_pkg::RET_OFF: retentive_no[step_dom_i] <= 1'b1;
        default: ;
      endcase
    end
  end

  // two-stage synchronizer, the switch cells answer asynchronously
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_meta_q <= '0;
      ack_sync_q <= '0;
    end else begin
      ack_meta_q <= switch_ack_ni;
      ack_sync_q <= ack_meta_q;
    end
  end

  assign ack_on_o  = !ack_sync_q[step_dom_i];
  assign ack_off_o = ack_sync_q[step_dom_i];

endmodule

/* design/pwr_sequencer.sv */
// power sequencer FSM
// checks each command, walks the gate steps and waits on the switch acknowledge

module pwr_sequencer #(
  parameter int unsigned NUM_DOMAINS = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   cmd_valid_i,
  input  pwr_pkg::pwr_cmd_u      cmd_word_i,
  input  logic                   core_sleep_i,
  input  logic                   wake_i,
  input  logic                   ack_on_i,
  input  logic                   ack_off_i,
  output pwr_pkg::pwr_step_e     step_o,
  output logic [((NUM_DOMAINS > 1) ? $clog2(NUM_DOMAINS) : 1)-1:0] step_dom_o,
  output logic                   busy_o,
  output logic                   dropped_o,
  output logic [NUM_DOMAINS-1:0] dom_on_o,
  output logic [NUM_DOMAINS-1:0] dom_ret_o
);

  localparam int unsigned DOM_W = (NUM_DOMAINS > 1) ? $clog2(NUM_DOMAINS) : 1;
  localparam logic [DOM_W-1:0] CPU_IDX = DOM_W'(mcu_cfg_pkg::DOM_CPU);

  pwr_pkg::seq_state_e  state_q, state_d;
  pwr_pkg::pwr_step_e   step_q, step_d;
  pwr_pkg::pwr_op_e     op_q, op_d;
  logic [DOM_W-1:0]     dom_q, dom_d;
  logic [NUM_DOMAINS-1:0] dom_on_q, dom_on_d;
  logic [NUM_DOMAINS-1:0] dom_ret_q, dom_ret_d;

  logic                 wake_req;
  logic                 req_go;
  pwr_pkg::pwr_op_e     req_op;
  logic [3:0]           req_dom;
  logic [DOM_W-1:0]     req_idx;

  // wake brings the cpu back, an external command in the same cycle wins
  assign wake_req = wake_i && !dom_on_q[CPU_IDX];
  assign req_go   = cmd_valid_i || wake_req;
  assign req_op   = cmd_valid_i ? cmd_word_i.f.op : pwr_pkg::PWR_ON;
  assign req_dom  = cmd_valid_i ? cmd_word_i.f.dom : mcu_cfg_pkg::DOM_CPU;
  assign req_idx  = req_dom[DOM_W-1:0];

  always_comb begin
    state_d   = state_q;
    step_d    = step_q;
    op_d      = op_q;
    dom_d     = dom_q;
    dom_on_d  = dom_on_q;
    dom_ret_d = dom_ret_q;
    case (state_q)
      pwr_pkg::SEQ_IDLE: begin
        if (req_go) begin
          op_d    = req_op;
          dom_d   = req_idx;
          state_d = pwr_pkg::SEQ_NOP;
          if (req_dom >= NUM_DOMAINS) begin
            state_d = pwr_pkg::SEQ_DROP;
          end else begin
            case (req_op)
              pwr_pkg::PWR_ON: begin
                if (!dom_on_q[req_idx]) begin
                  state_d = pwr_pkg::SEQ_RUN;
                  step_d  = dom_ret_q[req_idx] ? pwr_pkg::RET_OFF : pwr_pkg::SW_ON;
                end
              end
              pwr_pkg::PWR_OFF: begin
                if ((req_dom == mcu_cfg_pkg::DOM_CPU) && !core_sleep_i) begin
                  state_d = pwr_pkg::SEQ_DROP;
                end else if (dom_ret_q[req_idx]) begin
                  // retained to off needs a power-up first
                  state_d = pwr_pkg::SEQ_DROP;
                end else if (dom_on_q[req_idx]) begin
                  state_d = pwr_pkg::SEQ_RUN;
                  step_d  = pwr_pkg::CLK_OFF;
                end
              end
              pwr_pkg::PWR_RETAIN: begin
                if ((req_dom < mcu_cfg_pkg::DOM_FIRST_BANK) ||
                    (!dom_on_q[req_idx] && !dom_ret_q[req_idx])) begin
                  state_d = pwr_pkg::SEQ_DROP;
                end else if (dom_on_q[req_idx]) begin
                  state_d = pwr_pkg::SEQ_RUN;
                  step_d  = pwr_pkg::CLK_OFF;
                end
              end
              default: state_d = pwr_pkg::SEQ_NOP;
            endcase
          end
        end
      end
      pwr_pkg::SEQ_NOP, pwr_pkg::SEQ_DROP: state_d = pwr_pkg::SEQ_IDLE;
      pwr_pkg::SEQ_RUN: begin
        case (step_q)
          pwr_pkg::CLK_OFF: step_d = pwr_pkg::ISO_ON;
          pwr_pkg::ISO_ON: begin
            step_d = (op_q == pwr_pkg::PWR_RETAIN) ? pwr_pkg::RET_ON : pwr_pkg::RST_ON;
          end
          pwr_pkg::RST_ON:  step_d = pwr_pkg::SW_OFF;
          pwr_pkg::SW_OFF: begin
            step_d  = pwr_pkg::STEP_NONE;
            state_d = pwr_pkg::SEQ_WAIT_OFF;
          end
          pwr_pkg::RET_ON: begin
            dom_on_d[dom_q]  = 1'b0;
            dom_ret_d[dom_q] = 1'b1;
            step_d           = pwr_pkg::STEP_NONE;
            state_d          = pwr_pkg::SEQ_IDLE;
          end
          pwr_pkg::SW_ON: begin
            step_d  = pwr_pkg::STEP_NONE;
            state_d = pwr_pkg::SEQ_WAIT_ON;
          end
          pwr_pkg::RST_OFF, pwr_pkg::RET_OFF: step_d = pwr_pkg::ISO_OFF;
          pwr_pkg::ISO_OFF: step_d = pwr_pkg::CLK_ON;
          pwr_pkg::CLK_ON: begin
            dom_on_d[dom_q]  = 1'b1;
            dom_ret_d[dom_q] = 1'b0;
            step_d           = pwr_pkg::STEP_NONE;
            state_d          = pwr_pkg::SEQ_IDLE;
          end
          default: state_d = pwr_pkg::SEQ_IDLE;
        endcase
      end
      pwr_pkg::SEQ_WAIT_OFF: begin
        if (ack_off_i) begin
          dom_on_d[dom_q] = 1'b0;
          state_d         = pwr_pkg::SEQ_IDLE;
        end
      end
      pwr_pkg::SEQ_WAIT_ON: begin
        // switch is up, release reset, isolation and clock
        if (ack_on_i) begin
          step_d  = pwr_pkg::RST_OFF;
          state_d = pwr_pkg::SEQ_RUN;
        end
      end
      default: state_d = pwr_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= pwr_pkg::SEQ_IDLE;
      step_q    <= pwr_pkg::STEP_NONE;
      op_q      <= pwr_pkg::PWR_NOP;
      dom_q     <= '0;
      dom_on_q  <= '1;
      dom_ret_q <= '0;
    end else begin
      state_q   <= state_d;
      step_q    <= step_d;
      op_q      <= op_d;
      dom_q     <= dom_d;
      dom_on_q  <= dom_on_d;
      dom_ret_q <= dom_ret_d;
    end
  end

  assign step_o     = step_q;
  assign step_dom_o = dom_q;
  assign busy_o     = (state_q != pwr_pkg::SEQ_IDLE);
  assign dropped_o  = (state_q == pwr_pkg::SEQ_DROP);
  assign dom_on_o   = dom_on_q;
  assign dom_ret_o  = dom_ret_q;

endmodule

/* design/pwr_cmd_regs.sv */
// power and interrupt control registers
// accepts power commands, holds irq enables and software irq, reads back status

module pwr_cmd_regs #(
  parameter int unsigned NUM_DOMAINS = 4,
  parameter int unsigned FAST_IRQ_W  = 15
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                reg_we_i,
  input  logic [mcu_cfg_pkg::REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [mcu_cfg_pkg::REG_DATA_W-1:0]  reg_wdata_i,
  output logic [mcu_cfg_pkg::REG_DATA_W-1:0]  reg_rdata_o,
  input  logic                                busy_i,
  input  logic                                dropped_i,
  input  logic [NUM_DOMAINS-1:0]              dom_on_i,
  input  logic [NUM_DOMAINS-1:0]              dom_ret_i,
  input  logic [31:0]                         pending_i,
  output logic                                cmd_valid_o,
  output pwr_pkg::pwr_cmd_u                   cmd_word_o,
  output logic [31:0]                         irq_en_o,
  output logic [FAST_IRQ_W-1:0]               pend_clr_o,
  output logic                                sw_irq_o
);

  // status word layout
  localparam int unsigned STAT_ON_LSB  = 0;
  localparam int unsigned STAT_RET_LSB = 4;
  localparam int unsigned STAT_BUSY    = 8;
  localparam int unsigned STAT_DROPPED = 9;

  pwr_pkg::pwr_cmd_u cmd_q;
  logic [31:0]       irq_en_q;
  logic              sw_irq_q;
  logic              dropped_q;
  logic              wr_cmd;
  logic              wr_status;
  logic              wr_pend;

  assign wr_cmd    = reg_we_i && (reg_addr_i == mcu_cfg_pkg::ADDR_CMD);
  assign wr_status = reg_we_i && (reg_addr_i == mcu_cfg_pkg::ADDR_STATUS);
  assign wr_pend   = reg_we_i && (reg_addr_i == mcu_cfg_pkg::ADDR_IRQ_PEND);

  // a command is only handed over while the sequencer is idle
  assign cmd_valid_o = wr_cmd && !busy_i;
  assign cmd_word_o  = pwr_pkg::pwr_cmd_u'(reg_wdata_i);

  // write-1-to-clear on the fast pending bits
  assign pend_clr_o = wr_pend ? reg_wdata_i[mcu_cfg_pkg::IRQ_FAST_LSB +: FAST_IRQ_W] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_q     <= '0;
      irq_en_q  <= '0;
      sw_irq_q  <= 1'b0;
      dropped_q <= 1'b0;
    end else begin
      if (cmd_valid_o) begin
        cmd_q.raw <= reg_wdata_i;
      end
      if (reg_we_i && (reg_addr_i == mcu_cfg_pkg::ADDR_IRQ_EN)) begin
        irq_en_q <= reg_wdata_i;
      end
      if (reg_we_i && (reg_addr_i == mcu_cfg_pkg::ADDR_SW_IRQ)) begin
        sw_irq_q <= reg_wdata_i[0];
      end
      // sticky, a new drop wins over the clearing write
      if (dropped_i || (wr_cmd && busy_i)) begin
        dropped_q <= 1'b1;
      end else if (wr_status) begin
        dropped_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      mcu_cfg_pkg::ADDR_CMD: reg_rdata_o = cmd_q.raw;
      mcu_cfg_pkg::ADDR_STATUS: begin
        reg_rdata_o[STAT_ON_LSB +: NUM_DOMAINS]  = dom_on_i;
        reg_rdata_o[STAT_RET_LSB +: NUM_DOMAINS] = dom_ret_i;
        reg_rdata_o[STAT_BUSY]                   = busy_i;
        reg_rdata_o[STAT_DROPPED]                = dropped_q;
      end
      mcu_cfg_pkg::ADDR_IRQ_EN:   reg_rdata_o = irq_en_q;
      mcu_cfg_pkg::ADDR_IRQ_PEND: reg_rdata_o = pending_i;
      mcu_cfg_pkg::ADDR_SW_IRQ:   reg_rdata_o[0] = sw_irq_q;
      default: reg_rdata_o = '0;
    endcase
  end

  assign irq_en_o = irq_en_q;
  assign sw_irq_o = sw_irq_q;

endmodule

/* design/pwr_pkg.sv */
// power sequencing types
// operation codes, command word layout, gate steps and sequencer states

package pwr_pkg;

  typedef enum logic [1:0] {
    PWR_NOP    = 2'd0,
    PWR_ON     = 2'd1,
    PWR_OFF    = 2'd2,
    PWR_RETAIN = 2'd3
  } pwr_op_e;

  // command register fields
  typedef struct packed {
    logic [25:0] rsvd;
    logic [3:0]  dom;
    pwr_op_e     op;
  } pwr_cmd_t;

  // raw register word or decoded command
  typedef union packed {
    logic [31:0] raw;
    pwr_cmd_t    f;
  } pwr_cmd_u;

  // one gate action, applied to the selected domain
  typedef enum logic [3:0] {
    STEP_NONE = 4'd0,
    CLK_OFF   = 4'd1,
    ISO_ON    = 4'd2,
    RST_ON    = 4'd3,
    SW_OFF    = 4'd4,
    RET_ON    = 4'd5,
    SW_ON     = 4'd6,
    RST_OFF   = 4'd7,
    ISO_OFF   = 4'd8,
    CLK_ON    = 4'd9,
    RET_OFF   = 4'd10
  } pwr_step_e;

  typedef enum logic [2:0] {
    SEQ_IDLE     = 3'd0,
    SEQ_NOP      = 3'd1,
    SEQ_DROP     = 3'd2,
    SEQ_RUN      = 3'd3,
    SEQ_WAIT_OFF = 3'd4,
    SEQ_WAIT_ON  = 3'd5
  } seq_state_e;

endpackage

/* design/mcu_cfg_pkg.sv */
// mini MCU always-on block configuration
// register map, interrupt vector positions and domain indices

package mcu_cfg_pkg;

  // register port
  localparam int unsigned REG_ADDR_W = 4;
  localparam int unsigned REG_DATA_W = 32;

  // word addresses
  localparam logic [REG_ADDR_W-1:0] ADDR_CMD      = 4'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS   = 4'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_IRQ_EN   = 4'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_IRQ_PEND = 4'd3;
  localparam logic [REG_ADDR_W-1:0] ADDR_SW_IRQ   = 4'd4;

  // machine interrupt vector layout
  localparam int unsigned IRQ_SW_BIT    = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT   = 11;
  localparam int unsigned IRQ_FAST_LSB  = 16;

  // power domains, the memory banks follow the peripheral domain
  localparam logic [3:0] DOM_CPU        = 4'd0;
  localparam logic [3:0] DOM_PERIPH     = 4'd1;
  localparam logic [3:0] DOM_FIRST_BANK = DOM_PERIPH + 4'd1;

endpackage
